//--- simd_settings.svh
/*
 * Build-time sizes of the SIMD execution slice.
 * SIMD_VELEMENTS must equal SIMD_VLEN / SIMD_DATA_SIZE.
 * SIMD_QUEUE_DEPTH is also the number of issue credits upstream starts with.
 */
`ifndef SIMD_SETTINGS_SVH
`define SIMD_SETTINGS_SVH

`define SIMD_VLEN        128  // Vector register width in bits
`define SIMD_DATA_SIZE   64   // Width of one lane
`define SIMD_VELEMENTS   2    // Lanes per vector
`define SIMD_QUEUE_DEPTH 4
`define SIMD_WB_CREDITS  2

`endif

//--- simd_op_pkg.sv
/*
 * Instruction encodings seen by the SIMD unit.
 * Multiply, divide and floating point are not encoded.
 */
package simd_op_pkg;

    // SIMD opcodes
    typedef enum logic [3:0] {
        VADD    = 4'd0,
        VSUB    = 4'd1,
        VAND    = 4'd2,
        VOR     = 4'd3,
        VXOR    = 4'd4,
        VSEQ    = 4'd5,
        VMV_X_S = 4'd6,  // Element 0 to scalar
        VEXT    = 4'd7,  // Element rs1 to scalar
        VCNT    = 4'd8   // Length of the equal prefix
    } vop_e;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_e;

    // Source of the first operand
    typedef enum logic [1:0] {
        SRC_VV = 2'd0,
        SRC_VX = 2'd1,
        SRC_VI = 2'd2
    } vsrc_e;

endpackage

//--- simd_wb_pkg.sv
/*
 * Writeback side definitions.
 * Tags are architectural register numbers since renaming is not modelled.
 */
package simd_wb_pkg;

    localparam int TAG_W = 5;  // Destination register tag

    // Which register file takes the result
    typedef enum logic {
        WB_VECTOR = 1'b0,
        WB_SCALAR = 1'b1
    } wb_kind_e;

endpackage

//--- simd_issue_queue.sv
/*
 * In-order issue FIFO with a registered credit return per pop.
 * Upstream must hold a credit for every push. A push into a full queue is not blocked.
 * Pop on an empty queue is ignored.
 */
`timescale 1ns/10ps
`include "simd_settings.svh"

module simd_issue_queue (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             push_i,
    input  simd_op_pkg::vop_e                op_i,
    input  simd_op_pkg::sew_e                sew_i,
    input  simd_op_pkg::vsrc_e               src_i,
    input  logic [`SIMD_VLEN-1:0]            vs1_i,
    input  logic [`SIMD_VLEN-1:0]            vs2_i,
    input  logic [`SIMD_VLEN-1:0]            old_vd_i,
    input  logic [`SIMD_VLEN/8-1:0]          vm_i,
    input  logic [`SIMD_DATA_SIZE-1:0]       rs1_i,
    input  logic [`SIMD_DATA_SIZE-1:0]       imm_i,
    input  logic [simd_wb_pkg::TAG_W-1:0]    tag_i,
    input  logic                             pop_i,
    output logic                             empty_o,
    output simd_op_pkg::vop_e                op_o,
    output simd_op_pkg::sew_e                sew_o,
    output simd_op_pkg::vsrc_e               src_o,
    output logic [`SIMD_VLEN-1:0]            vs1_o,
    output logic [`SIMD_VLEN-1:0]            vs2_o,
    output logic [`SIMD_VLEN-1:0]            old_vd_o,
    output logic [`SIMD_VLEN/8-1:0]          vm_o,
    output logic [`SIMD_DATA_SIZE-1:0]       rs1_o,
    output logic [`SIMD_DATA_SIZE-1:0]       imm_o,
    output logic [simd_wb_pkg::TAG_W-1:0]    tag_o,
    output logic                             credit_o
);

localparam int PTR_W = $clog2(`SIMD_QUEUE_DEPTH);
localparam int CNT_W = $clog2(`SIMD_QUEUE_DEPTH + 1);

simd_op_pkg::vop_e             op_mem     [`SIMD_QUEUE_DEPTH];
simd_op_pkg::sew_e             sew_mem    [`SIMD_QUEUE_DEPTH];
simd_op_pkg::vsrc_e            src_mem    [`SIMD_QUEUE_DEPTH];
logic [`SIMD_VLEN-1:0]         vs1_mem    [`SIMD_QUEUE_DEPTH];
logic [`SIMD_VLEN-1:0]         vs2_mem    [`SIMD_QUEUE_DEPTH];
logic [`SIMD_VLEN-1:0]         old_vd_mem [`SIMD_QUEUE_DEPTH];
logic [`SIMD_VLEN/8-1:0]       vm_mem     [`SIMD_QUEUE_DEPTH];
logic [`SIMD_DATA_SIZE-1:0]    rs1_mem    [`SIMD_QUEUE_DEPTH];
logic [`SIMD_DATA_SIZE-1:0]    imm_mem    [`SIMD_QUEUE_DEPTH];
logic [simd_wb_pkg::TAG_W-1:0] tag_mem    [`SIMD_QUEUE_DEPTH];

logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;  // Occupied entries
logic             do_pop;

assign empty_o = (count == '0);
assign do_pop  = pop_i && !empty_o;

always_ff @(posedge clk_i) begin
    if (push_i) begin
        op_mem[wr_ptr]     <= op_i;
        sew_mem[wr_ptr]    <= sew_i;
        src_mem[wr_ptr]    <= src_i;
        vs1_mem[wr_ptr]    <= vs1_i;
        vs2_mem[wr_ptr]    <= vs2_i;
        old_vd_mem[wr_ptr] <= old_vd_i;
        vm_mem[wr_ptr]     <= vm_i;
        rs1_mem[wr_ptr]    <= rs1_i;
        imm_mem[wr_ptr]    <= imm_i;
        tag_mem[wr_ptr]    <= tag_i;
    end
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        wr_ptr   <= '0;
        rd_ptr   <= '0;
        count    <= '0;
        credit_o <= 1'b0;
    end else begin
        if (push_i) begin
            wr_ptr <= (wr_ptr == PTR_W'(`SIMD_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(`SIMD_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        case ({push_i, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;  // Both or neither leave the count as is
        endcase
        credit_o <= do_pop;  // One credit back per entry freed
    end
end

// Head entry is visible without a read cycle
assign op_o     = op_mem[rd_ptr];
assign sew_o    = sew_mem[rd_ptr];
assign src_o    = src_mem[rd_ptr];
assign vs1_o    = vs1_mem[rd_ptr];
assign vs2_o    = vs2_mem[rd_ptr];
assign old_vd_o = old_vd_mem[rd_ptr];
assign vm_o     = vm_mem[rd_ptr];
assign rs1_o    = rs1_mem[rd_ptr];
assign imm_o    = imm_mem[rd_ptr];
assign tag_o    = tag_mem[rd_ptr];

endmodule

//--- functional_unit.sv
/*
 * One 64-bit SIMD lane. Element boundaries follow sew_i.
 * Carries never cross an element boundary.
 * VSEQ and VCNT put a 1 or 0 in bit 0 of each element and clear the rest.
 */
`timescale 1ns/10ps
`include "simd_settings.svh"

module functional_unit (
    input  simd_op_pkg::vop_e          op_i,
    input  simd_op_pkg::sew_e          sew_i,
    input  logic [`SIMD_DATA_SIZE-1:0] data_vs1_i,
    input  logic [`SIMD_DATA_SIZE-1:0] data_vs2_i,
    output logic [`SIMD_DATA_SIZE-1:0] data_vd_o
);

localparam int NBYTES = `SIMD_DATA_SIZE / 8;

logic [3:0]                 emask;  // Bytes per element minus one
logic                       is_sub;
logic [`SIMD_DATA_SIZE-1:0] opnd_b;
logic [`SIMD_DATA_SIZE-1:0] sum;
logic [`SIMD_DATA_SIZE-1:0] cmp;

assign emask  = (4'd1 << sew_i) - 4'd1;
assign is_sub = (op_i == simd_op_pkg::VSUB);
assign opnd_b = is_sub ? ~data_vs1_i : data_vs1_i;  // vs2 - vs1 as vs2 + ~vs1 + 1

// Byte-wide adder chain, cut at every element start
always_comb begin
    logic carry;
    carry = 1'b0;
    for (int b = 0; b < NBYTES; b++) begin
        if ((b & emask) == 0) begin
            carry = is_sub;
        end
        {carry, sum[b*8 +: 8]} = data_vs2_i[b*8 +: 8] + opnd_b[b*8 +: 8] + carry;
    end
end

always_comb begin
    logic run;
    run = 1'b1;
    cmp = '0;
    for (int b = 0; b < NBYTES; b++) begin
        if ((b & emask) == 0) begin
            run = 1'b1;
        end
        run = run & (data_vs2_i[b*8 +: 8] == data_vs1_i[b*8 +: 8]);
        // Last byte of the element decides the flag
        if ((b & emask) == emask) begin
            cmp[(b - emask) * 8] = run;
        end
    end
end

always_comb begin
    case (op_i)
        simd_op_pkg::VADD,
        simd_op_pkg::VSUB: data_vd_o = sum;
        simd_op_pkg::VAND: data_vd_o = data_vs2_i & data_vs1_i;
        simd_op_pkg::VOR:  data_vd_o = data_vs2_i | data_vs1_i;
        simd_op_pkg::VXOR: data_vd_o = data_vs2_i ^ data_vs1_i;
        simd_op_pkg::VSEQ,
        simd_op_pkg::VCNT: data_vd_o = cmp;
        default:           data_vd_o = '0;  // Scalar ops do not use the lanes
    endcase
end

endmodule

//--- simd_scalar_extract.sv
/*
 * Scalar result of VMV_X_S and VEXT.
 * The element is zero-extended at every SEW.
 * The VEXT index wraps modulo the element count at the current SEW.
 */
`timescale 1ns/10ps
`include "simd_settings.svh"

module simd_scalar_extract (
    input  simd_op_pkg::vop_e          op_i,
    input  simd_op_pkg::sew_e          sew_i,
    input  logic [`SIMD_VLEN-1:0]      vs2_i,
    input  logic [`SIMD_DATA_SIZE-1:0] rs1_i,
    output logic [`SIMD_DATA_SIZE-1:0] scalar_o
);

localparam int IDX_W = $clog2(`SIMD_VLEN / 8);  // Enough for the SEW_8 element count

logic [6:0]                 width;     // Element width in bits
logic [IDX_W-1:0]           idx_mask;
logic [IDX_W-1:0]           idx;
logic [`SIMD_VLEN-1:0]      shifted;
logic [`SIMD_DATA_SIZE-1:0] elem_mask;
logic                       is_extract;

assign width    = 7'd8 << sew_i;
assign idx_mask = IDX_W'(((`SIMD_VLEN / 8) >> sew_i) - 1);

// VMV_X_S is element 0
assign idx = (op_i == simd_op_pkg::VEXT) ? (rs1_i[IDX_W-1:0] & idx_mask) : '0;

assign shifted   = vs2_i >> (idx * width);
assign elem_mask = {`SIMD_DATA_SIZE{1'b1}} >> (7'd64 - width);

assign is_extract = (op_i == simd_op_pkg::VMV_X_S) || (op_i == simd_op_pkg::VEXT);
assign scalar_o   = is_extract ? (shifted[`SIMD_DATA_SIZE-1:0] & elem_mask) : '0;

endmodule

//--- simd_result_merge.sv
/*
 * Final SIMD result. The write mask uses the bit of the first byte of each element.
 * VCNT counts the equal flags from element 0 up to the first clear one.
 * Scalar ops still drive vresult_o, but only result_o is meaningful for them.
 */
`timescale 1ns/10ps
`include "simd_settings.svh"

module simd_result_merge (
    input  simd_op_pkg::vop_e          op_i,
    input  simd_op_pkg::sew_e          sew_i,
    input  logic [`SIMD_VLEN-1:0]      lanes_vd_i,
    input  logic [`SIMD_VLEN-1:0]      old_vd_i,
    input  logic [`SIMD_VLEN/8-1:0]    vm_i,
    input  logic [`SIMD_DATA_SIZE-1:0] scalar_i,
    output simd_wb_pkg::wb_kind_e      kind_o,
    output logic [`SIMD_VLEN-1:0]      vresult_o,
    output logic [`SIMD_DATA_SIZE-1:0] result_o
);

localparam int VBYTES = `SIMD_VLEN / 8;
localparam int DW     = `SIMD_DATA_SIZE;

logic [3:0] emask;  // Bytes per element minus one
logic [4:0] cnt;

assign emask = (4'd1 << sew_i) - 4'd1;

always_comb begin
    vresult_o = old_vd_i;
    for (int b = 0; b < VBYTES; b++) begin
        if (vm_i[b & ~int'(emask)]) begin
            vresult_o[b*8 +: 8] = lanes_vd_i[b*8 +: 8];
        end
    end
end

// Equal prefix length, lanes left the flag in bit 0 of each element
always_comb begin
    logic stop;
    stop = 1'b0;
    cnt  = '0;
    for (int b = 0; b < VBYTES; b++) begin
        if ((b & emask) == 0) begin
            if (!stop && lanes_vd_i[b*8]) begin
                cnt = cnt + 5'd1;
            end else begin
                stop = 1'b1;
            end
        end
    end
end

assign result_o = (op_i == simd_op_pkg::VCNT) ? DW'(cnt) : scalar_i;

always_comb begin
    case (op_i)
        simd_op_pkg::VMV_X_S,
        simd_op_pkg::VEXT,
        simd_op_pkg::VCNT: kind_o = simd_wb_pkg::WB_SCALAR;
        default:           kind_o = simd_wb_pkg::WB_VECTOR;
    endcase
end

endmodule

//--- simd_unit.sv
/*
 * Single-pass combinational SIMD datapath.
 * For SRC_VX and SRC_VI the low SEW bits of rs1 or imm fill every element.
 * Results are valid in the same cycle as the inputs.
 */
`timescale 1ns/10ps
`include "simd_settings.svh"

module simd_unit (
    input  simd_op_pkg::vop_e          op_i,
    input  simd_op_pkg::sew_e          sew_i,
    input  simd_op_pkg::vsrc_e         src_i,
    input  logic [`SIMD_VLEN-1:0]      vs1_i,
    input  logic [`SIMD_VLEN-1:0]      vs2_i,
    input  logic [`SIMD_VLEN-1:0]      old_vd_i,
    input  logic [`SIMD_VLEN/8-1:0]    vm_i,
    input  logic [`SIMD_DATA_SIZE-1:0] rs1_i,
    input  logic [`SIMD_DATA_SIZE-1:0] imm_i,
    output simd_wb_pkg::wb_kind_e      kind_o,
    output logic [`SIMD_VLEN-1:0]      vresult_o,
    output logic [`SIMD_DATA_SIZE-1:0] result_o
);

localparam int VBYTES = `SIMD_VLEN / 8;
localparam int DW     = `SIMD_DATA_SIZE;

logic [3:0]                 emask;
logic [`SIMD_DATA_SIZE-1:0] scalar;      // rs1 or imm before replication
logic [`SIMD_VLEN-1:0]      replicated;
logic [`SIMD_VLEN-1:0]      opnd_vs1;
logic [`SIMD_VLEN-1:0]      lanes_vd;
logic [`SIMD_DATA_SIZE-1:0] extracted;

assign emask  = (4'd1 << sew_i) - 4'd1;
assign scalar = (src_i == simd_op_pkg::SRC_VX) ? rs1_i : imm_i;

// Each byte copies the byte at the same offset inside element 0
always_comb begin
    for (int b = 0; b < VBYTES; b++) begin
        replicated[b*8 +: 8] = scalar[(b & emask)*8 +: 8];
    end
end

assign opnd_vs1 = (src_i == simd_op_pkg::SRC_VV) ? vs1_i : replicated;

for (genvar i = 0; i < `SIMD_VELEMENTS; i++) begin : g_lane
    functional_unit functional_unit_i (
        .op_i       (op_i),
        .sew_i      (sew_i),
        .data_vs1_i (opnd_vs1[i*DW +: DW]),
        .data_vs2_i (vs2_i[i*DW +: DW]),
        .data_vd_o  (lanes_vd[i*DW +: DW])
    );
end

simd_scalar_extract simd_scalar_extract_i (
    .op_i     (op_i),
    .sew_i    (sew_i),
    .vs2_i    (vs2_i),
    .rs1_i    (rs1_i),
    .scalar_o (extracted)
);

simd_result_merge simd_result_merge_i (
    .op_i       (op_i),
    .sew_i      (sew_i),
    .lanes_vd_i (lanes_vd),
    .old_vd_i   (old_vd_i),
    .vm_i       (vm_i),
    .scalar_i   (extracted),
    .kind_o     (kind_o),
    .vresult_o  (vresult_o),
    .result_o   (result_o)
);

endmodule

//--- simd_exec_top.sv
/*
 * SIMD execution slice with credit flow control on both ports.
 * Upstream starts with SIMD_QUEUE_DEPTH credits, one returned per issue_credit_o pulse.
 * Downstream returns at most one writeback credit per cycle on wb_credit_i.
 * Issue to writeback takes 2 cycles at best. Results stay in issue order.
 */
`timescale 1ns/10ps
`include "simd_settings.svh"

module simd_exec_top (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             issue_valid_i,
    input  simd_op_pkg::vop_e                issue_op_i,
    input  simd_op_pkg::sew_e                issue_sew_i,
    input  simd_op_pkg::vsrc_e               issue_src_i,
    input  logic [`SIMD_VLEN-1:0]            issue_vs1_i,
    input  logic [`SIMD_VLEN-1:0]            issue_vs2_i,
    input  logic [`SIMD_VLEN-1:0]            issue_old_vd_i,
    input  logic [`SIMD_VLEN/8-1:0]          issue_vm_i,
    input  logic [`SIMD_DATA_SIZE-1:0]       issue_rs1_i,
    input  logic [`SIMD_DATA_SIZE-1:0]       issue_imm_i,
    input  logic [simd_wb_pkg::TAG_W-1:0]    issue_tag_i,
    output logic                             issue_credit_o,
    output logic                             wb_valid_o,
    output simd_wb_pkg::wb_kind_e            wb_kind_o,
    output logic [`SIMD_VLEN-1:0]            wb_vresult_o,
    output logic [`SIMD_DATA_SIZE-1:0]       wb_result_o,
    output logic [simd_wb_pkg::TAG_W-1:0]    wb_tag_o,
    input  logic                             wb_credit_i
);

localparam int WB_CNT_W = $clog2(`SIMD_WB_CREDITS + 1);

logic                          q_empty;
simd_op_pkg::vop_e             head_op;
simd_op_pkg::sew_e             head_sew;
simd_op_pkg::vsrc_e            head_src;
logic [`SIMD_VLEN-1:0]         head_vs1;
logic [`SIMD_VLEN-1:0]         head_vs2;
logic [`SIMD_VLEN-1:0]         head_old_vd;
logic [`SIMD_VLEN/8-1:0]       head_vm;
logic [`SIMD_DATA_SIZE-1:0]    head_rs1;
logic [`SIMD_DATA_SIZE-1:0]    head_imm;
logic [simd_wb_pkg::TAG_W-1:0] head_tag;

simd_wb_pkg::wb_kind_e         unit_kind;
logic [`SIMD_VLEN-1:0]         unit_vresult;
logic [`SIMD_DATA_SIZE-1:0]    unit_result;

logic [WB_CNT_W-1:0]           wb_credits;  // Writeback credits still available
logic                          pop;

simd_issue_queue simd_issue_queue_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .push_i   (issue_valid_i),
    .op_i     (issue_op_i),
    .sew_i    (issue_sew_i),
    .src_i    (issue_src_i),
    .vs1_i    (issue_vs1_i),
    .vs2_i    (issue_vs2_i),
    .old_vd_i (issue_old_vd_i),
    .vm_i     (issue_vm_i),
    .rs1_i    (issue_rs1_i),
    .imm_i    (issue_imm_i),
    .tag_i    (issue_tag_i),
    .pop_i    (pop),
    .empty_o  (q_empty),
    .op_o     (head_op),
    .sew_o    (head_sew),
    .src_o    (head_src),
    .vs1_o    (head_vs1),
    .vs2_o    (head_vs2),
    .old_vd_o (head_old_vd),
    .vm_o     (head_vm),
    .rs1_o    (head_rs1),
    .imm_o    (head_imm),
    .tag_o    (head_tag),
    .credit_o (issue_credit_o)
);

simd_unit simd_unit_i (
    .op_i      (head_op),
    .sew_i     (head_sew),
    .src_i     (head_src),
    .vs1_i     (head_vs1),
    .vs2_i     (head_vs2),
    .old_vd_i  (head_old_vd),
    .vm_i      (head_vm),
    .rs1_i     (head_rs1),
    .imm_i     (head_imm),
    .kind_o    (unit_kind),
    .vresult_o (unit_vresult),
    .result_o  (unit_result)
);

// A pop raises wb_valid_o on the next edge, so the credit is taken at the pop
assign pop = !q_empty && (wb_credits != '0);

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        wb_credits <= WB_CNT_W'(`SIMD_WB_CREDITS);
        wb_valid_o <= 1'b0;
    end else begin
        case ({pop, wb_credit_i})
            2'b10:   wb_credits <= wb_credits - 1'b1;
            2'b01:   wb_credits <= wb_credits + 1'b1;
            default: ;
        endcase
        wb_valid_o <= pop;
    end
end

// Writeback payload, captured from the unit on each pop
always_ff @(posedge clk_i) begin
    if (pop) begin
        wb_kind_o    <= unit_kind;
        wb_vresult_o <= unit_vresult;
        wb_result_o  <= unit_result;
        wb_tag_o     <= head_tag;
    end
end

endmodule

//--- simd_exec_asserts.sv
/*
 * Concurrent checks bound into simd_exec_top.
 * Queue occupancy and writeback credits are modelled from the top-level port activity.
 * Needs a simulator run with assertions enabled.
 */
`timescale 1ns/10ps
`include "simd_settings.svh"

module simd_exec_asserts (
    input logic                                     clk_i,
    input logic                                     rst_n_i,
    input logic                                     push_i,
    input logic                                     pop_i,
    input logic [$clog2(`SIMD_WB_CREDITS + 1)-1:0]  wb_credits_i,
    input logic                                     wb_valid_i,
    input logic                                     wb_credit_i,
    input logic                                     issue_credit_i
);

localparam int OCC_W = $clog2(`SIMD_QUEUE_DEPTH + 1) + 1;
localparam int PWB_W = $clog2(`SIMD_WB_CREDITS + 1) + 1;

logic [OCC_W-1:0] occupancy;     // Entries held by the issue queue
logic [PWB_W-1:0] port_credits;  // Writeback credits seen on the ports
int               failures = 0;  // Assertion failures so far

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        occupancy <= '0;
    end else begin
        case ({push_i, pop_i})
            2'b10:   occupancy <= occupancy + 1'b1;
            2'b01:   occupancy <= occupancy - 1'b1;
            default: ;
        endcase
    end
end

// Spent per wb_valid_o cycle, returned per wb_credit_i pulse
always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        port_credits <= PWB_W'(`SIMD_WB_CREDITS);
    end else begin
        case ({wb_valid_i, wb_credit_i})
            2'b10:   port_credits <= port_credits - 1'b1;
            2'b01:   port_credits <= port_credits + 1'b1;
            default: ;
        endcase
    end
end

// Every writeback cycle needs a credit left over from earlier cycles
valid_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_valid_i |-> port_credits != '0)
    else begin
        failures++;
        $error("wb_valid_o was raised without a writeback credit");
    end

credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    int'(wb_credits_i) <= `SIMD_WB_CREDITS)
    else begin
        failures++;
        $error("Writeback credit counter above its initial value");
    end

no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> int'(occupancy) < `SIMD_QUEUE_DEPTH)
    else begin
        failures++;
        $error("Issue queue pushed while full");
    end

credit_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_credit_i == wb_valid_i)
    else begin
        failures++;
        $error("issue_credit_o and wb_valid_o out of step");
    end

endmodule

bind simd_exec_top simd_exec_asserts simd_exec_asserts_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .push_i         (issue_valid_i),
    .pop_i          (pop),
    .wb_credits_i   (wb_credits),
    .wb_valid_i     (wb_valid_o),
    .wb_credit_i    (wb_credit_i),
    .issue_credit_i (issue_credit_o)
);

//--- tb_simd_exec.sv
/*
 * Testbench for simd_exec_top. Tests and expected results come from simd_exec_tests.txt.
 * Issues only while holding an issue credit. Writeback credits return at random,
 * with one window of 20 cycles where none are returned.
 * Vector results are compared for WB_VECTOR tests, scalar results for WB_SCALAR tests.
 */
`timescale 1ns/10ps
`include "simd_settings.svh"

module tb_simd_exec;

localparam int MAX_TESTS   = 64;
localparam int HOLD_START  = 12;  // First cycle of the credit hold window
localparam int HOLD_CYCLES = 20;

logic                             clk_i;
logic                             rst_n_i;
logic                             issue_valid_i;
simd_op_pkg::vop_e                issue_op_i;
simd_op_pkg::sew_e                issue_sew_i;
simd_op_pkg::vsrc_e               issue_src_i;
logic [`SIMD_VLEN-1:0]            issue_vs1_i;
logic [`SIMD_VLEN-1:0]            issue_vs2_i;
logic [`SIMD_VLEN-1:0]            issue_old_vd_i;
logic [`SIMD_VLEN/8-1:0]          issue_vm_i;
logic [`SIMD_DATA_SIZE-1:0]       issue_rs1_i;
logic [`SIMD_DATA_SIZE-1:0]       issue_imm_i;
logic [simd_wb_pkg::TAG_W-1:0]    issue_tag_i;
logic                             issue_credit_o;
logic                             wb_valid_o;
simd_wb_pkg::wb_kind_e            wb_kind_o;
logic [`SIMD_VLEN-1:0]            wb_vresult_o;
logic [`SIMD_DATA_SIZE-1:0]       wb_result_o;
logic [simd_wb_pkg::TAG_W-1:0]    wb_tag_o;
logic                             wb_credit_i;

// Test table as read from the file
logic [3:0]                    t_op   [MAX_TESTS];
logic [1:0]                    t_sew  [MAX_TESTS];
logic [1:0]                    t_src  [MAX_TESTS];
logic [`SIMD_VLEN-1:0]         t_vs1  [MAX_TESTS];
logic [`SIMD_VLEN-1:0]         t_vs2  [MAX_TESTS];
logic [`SIMD_VLEN-1:0]         t_old  [MAX_TESTS];
logic [`SIMD_VLEN/8-1:0]       t_vm   [MAX_TESTS];
logic [`SIMD_DATA_SIZE-1:0]    t_rs1  [MAX_TESTS];
logic [`SIMD_DATA_SIZE-1:0]    t_imm  [MAX_TESTS];
logic [simd_wb_pkg::TAG_W-1:0] t_tag  [MAX_TESTS];
logic                          t_kind [MAX_TESTS];
logic [`SIMD_VLEN-1:0]         t_vres [MAX_TESTS];
logic [`SIMD_DATA_SIZE-1:0]    t_res  [MAX_TESTS];

int   n_tests          = 0;
int   issued           = 0;
int   received         = 0;
int   credit_pulses    = 0;  // issue_credit_o pulses seen
int   credits_returned = 0;  // wb_credit_i pulses driven
int   held_results     = 0;
int   mismatches       = 0;
int   other_errors     = 0;
int   cycles           = 0;
int   timeout_limit    = 1000;
logic withhold;
int   exp_q[$];              // Test indices in issue order

simd_exec_top simd_exec_top_i (.*);

initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
end

task automatic load_tests();
    int    fd;
    int    n;
    string line;
    fd = $fopen("simd_exec_tests.txt", "r");
    if (fd == 0) begin
        $display("Cannot open simd_exec_tests.txt");
        return;
    end
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
        if ($fgets(line, fd) == 0) break;
        if (line.len() < 3 || line.substr(0, 0) == "#") continue;  // Comment or blank
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                    t_op[n_tests], t_sew[n_tests], t_src[n_tests], t_vs1[n_tests],
                    t_vs2[n_tests], t_old[n_tests], t_vm[n_tests], t_rs1[n_tests],
                    t_imm[n_tests], t_tag[n_tests], t_kind[n_tests], t_vres[n_tests],
                    t_res[n_tests]);
        if (n != 13) begin
            $display("Malformed test line skipped: %s", line);
            other_errors++;
        end else begin
            n_tests++;
        end
    end
    $fclose(fd);
endtask

task automatic issue_test(input int idx);
    issue_op_i     = simd_op_pkg::vop_e'(t_op[idx]);
    issue_sew_i    = simd_op_pkg::sew_e'(t_sew[idx]);
    issue_src_i    = simd_op_pkg::vsrc_e'(t_src[idx]);
    issue_vs1_i    = t_vs1[idx];
    issue_vs2_i    = t_vs2[idx];
    issue_old_vd_i = t_old[idx];
    issue_vm_i     = t_vm[idx];
    issue_rs1_i    = t_rs1[idx];
    issue_imm_i    = t_imm[idx];
    issue_tag_i    = t_tag[idx];
    issue_valid_i  = 1'b1;
    exp_q.push_back(idx);
    issued++;
endtask

task automatic check_result(input int idx);
    assert (wb_tag_o == t_tag[idx]) else begin
        $display("Mismatch at %0t: wb_tag_o expected %h, actual %h", $time, t_tag[idx], wb_tag_o);
        mismatches++;
    end
    assert (wb_kind_o == simd_wb_pkg::wb_kind_e'(t_kind[idx])) else begin
        $display("Mismatch at %0t: wb_kind_o expected %0d, actual %0d",
                 $time, t_kind[idx], wb_kind_o);
        mismatches++;
    end
    if (t_kind[idx] == 1'b0) begin
        assert (wb_vresult_o == t_vres[idx]) else begin
            $display("Mismatch at %0t: wb_vresult_o expected %h, actual %h",
                     $time, t_vres[idx], wb_vresult_o);
            mismatches++;
        end
    end else begin
        assert (wb_result_o == t_res[idx]) else begin
            $display("Mismatch at %0t: wb_result_o expected %h, actual %h",
                     $time, t_res[idx], wb_result_o);
            mismatches++;
        end
    end
endtask

// Outputs are sampled on the falling edge, half a cycle after they change
always @(negedge clk_i) begin
    int idx;
    if (rst_n_i) begin
        if (issue_credit_o) credit_pulses++;
        if (wb_valid_o) begin
            if (withhold) held_results++;
            assert (exp_q.size() > 0) else begin
                $display("Writeback at %0t with no instruction outstanding", $time);
                other_errors++;
            end
            if (exp_q.size() > 0) begin
                idx = exp_q.pop_front();
                check_result(idx);
            end
            received++;
        end
    end
end

always @(posedge clk_i) begin
    if (rst_n_i) begin
        cycles++;
        if (cycles >= timeout_limit) begin
            $display("Timeout after %0d cycles, %0d of %0d results arrived",
                     cycles, received, n_tests);
            $display("test failed");
            $finish;
        end
    end
end

// Writeback credit return, one pulse per cycle at most
initial begin
    void'($urandom(32'h6a32));
    wb_credit_i = 1'b0;
    withhold    = 1'b0;
    @(posedge rst_n_i);
    forever begin
        @(posedge clk_i);
        #1;
        wb_credit_i = 1'b0;
        withhold    = (cycles >= HOLD_START) && (cycles < HOLD_START + HOLD_CYCLES);
        if (!withhold && received > credits_returned && ($urandom % 3) != 0) begin
            wb_credit_i = 1'b1;
            credits_returned++;
        end
    end
end

initial begin
    rst_n_i        = 1'b0;
    issue_valid_i  = 1'b0;
    issue_op_i     = simd_op_pkg::VADD;
    issue_sew_i    = simd_op_pkg::SEW_8;
    issue_src_i    = simd_op_pkg::SRC_VV;
    issue_vs1_i    = '0;
    issue_vs2_i    = '0;
    issue_old_vd_i = '0;
    issue_vm_i     = '0;
    issue_rs1_i    = '0;
    issue_imm_i    = '0;
    issue_tag_i    = '0;
    load_tests();
    timeout_limit = 50 * n_tests + 100;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    for (int t = 0; t < n_tests; t++) begin
        issue_valid_i = 1'b0;
        while (`SIMD_QUEUE_DEPTH + credit_pulses - issued <= 0) begin  // No issue credit
            @(posedge clk_i);
            #1;
        end
        issue_test(t);
        @(posedge clk_i);
        #1;
    end
    issue_valid_i = 1'b0;

    wait (received >= n_tests);
    repeat (3) @(posedge clk_i);

    assert (n_tests > 0) else begin
        $display("No tests were loaded");
        other_errors++;
    end
    assert (credit_pulses == n_tests) else begin
        $display("Mismatch at %0t: issue_credit_o pulses expected %0d, actual %0d",
                 $time, n_tests, credit_pulses);
        mismatches++;
    end
    assert (held_results <= `SIMD_WB_CREDITS) else begin
        $display("%0d results arrived while writeback credits were withheld", held_results);
        other_errors++;
    end
    assert (simd_exec_top_i.simd_exec_asserts_i.failures == 0) else begin
        $display("%0d bound assertion checks failed",
                 simd_exec_top_i.simd_exec_asserts_i.failures);
        other_errors++;
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
        $display("test passed");
    end else begin
        $display("test failed");
    end
    $finish;
end

endmodule

//--- simd_exec_tests.txt
# op sew src vs1 vs2 old_vd vm rs1 imm tag, then expected kind vresult result, all hex
# op 0..8 = add sub and or xor seq mv_x_s ext cnt, sew 0..3 = 8..64 bits, src 0 vv 1 vx 2 vi
0 0 0 01010101010101010101010101010101 ffffffffffffffffffffffffffffffff 0 ffff 0 0 01 0 0 0
0 1 0 00010001000100010001000100010001 ffff00ffffff00ffffff00ffffff00ff 0 ffff 0 0 02 0 00000100000001000000010000000100 0
0 2 1 0 ffffffff7fffffff00000005ffffffff 0 ffff ffffffff00000001 0 03 0 00000000800000000000000600000000 0
0 3 2 0 0000000000000010ffffffffffffffff 0 ffff 5 1 04 0 00000000000000110000000000000000 0
1 0 0 01010101010101010101010101010101 3 0 ffff 0 0 05 0 ffffffffffffffffffffffffffffff02 0
1 1 1 0 102 0 ffff 70002 0 06 0 fffefffefffefffefffefffefffe0100 0
1 2 2 0 0000000f000000100000001100000000 0 ffff 0 10 07 0 ffffffff0000000000000001fffffff0 0
1 3 0 00000000000000020000000000000001 00000000000000010000000000000000 0 ffff 0 0 08 0 ffffffffffffffffffffffffffffffff 0
2 0 0 ffffffffffffffff00000000000000ff 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa 00ff 0 0 09 0 aaaaaaaaaaaaaaaa000000000000000f 0
3 1 1 0 00100020003000400050006000700080 11112222333344445555666677778888 3311 8001 0 0a 0 11118021333380415555806177778081 0
4 2 2 0 0123456789abcdef0011223344556677 deadbeefdeadbeefdeadbeefdeadbeef 0f0f 0 ffffffff 0b 0 deadbeef76543210deadbeefbbaa9988 0
4 3 0 00000000ffffffff1111111111111111 ffffffffffffffff0000000000000000 22222222222222223333333333333333 0100 0 0 0c 0 ffffffff000000003333333333333333 0
2 3 1 0 123456789abcdef0123456789abcdef0 0 ffff ffff0000 0 0d 0 000000009abc0000000000009abc0000 0
3 0 2 0 000102030405060708090a0b0c0d0e0f 0 ffff 0 1234567890abcd80 0e 0 808182838485868788898a8b8c8d8e8f 0
5 1 0 00010000000300000005000000070000 00010002000300040005000600070008 0 ffff 0 0 0f 0 00010000000100000001000000010000 0
6 0 0 0 0123456789abcdef00112233445566f5 0 0 0 0 10 1 0 f5
6 1 0 0 0123456789abcdef00112233445566f5 0 0 0 0 11 1 0 66f5
6 2 0 0 0123456789abcdef00112233445566f5 0 0 0 0 12 1 0 445566f5
6 3 0 0 0123456789abcdef00112233445566f5 0 0 0 0 13 1 0 00112233445566f5
7 0 0 0 0123456789abcdef00112233445566f5 0 0 3 0 14 1 0 44
7 1 0 0 0123456789abcdef00112233445566f5 0 0 d 0 15 1 0 89ab
7 2 0 0 0123456789abcdef00112233445566f5 0 0 6 0 16 1 0 89abcdef
7 3 0 0 0123456789abcdef00112233445566f5 0 0 3 0 17 1 0 0123456789abcdef
8 0 0 1 0 0 0 0 0 18 1 0 0
8 1 0 0001000200ff00040005000600070008 00010002000300040005000600070008 0 0 0 0 19 1 0 5
8 2 0 0123456789abcdef0011223344556677 0123456789abcdef0011223344556677 0 0 0 0 1a 1 0 4

//--- all.f
+incdir+.
simd_op_pkg.sv
simd_wb_pkg.sv
simd_issue_queue.sv
functional_unit.sv
simd_scalar_extract.sv
simd_result_merge.sv
simd_unit.sv
simd_exec_top.sv
simd_exec_asserts.sv
tb_simd_exec.sv

//--- run.sh
#!/bin/sh
# Compile and run the SIMD execution slice testbench with Verilator.
# Exits non-zero if the build or the run fails or the log reports a failure.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_simd_exec -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_simd_exec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "test passed" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
